// ==== common/fpu_lite_defines.svh ====
// Single precision only and XLEN fixed at 32 so no NaN boxing or sign extension is applied
`ifndef FPU_LITE_DEFINES_SVH
`define FPU_LITE_DEFINES_SVH

// ==========================================================================
// Word and field widths
// ==========================================================================
`define FPU_FLEN      32          // FP register width
`define FPU_XLEN      32          // Integer register width
`define FPU_EXP_W     8           // Biased exponent
`define FPU_MAN_W     23          // Stored fraction
`define FPU_CLASS_W   10          // FCLASS mask width
`define FPU_OP_W      4           // Opcode width

// Bit positions inside an FP word
`define FPU_SIGN_BIT  31
`define FPU_EXP_MSB   30
`define FPU_EXP_LSB   23
`define FPU_QNAN_BIT  22          // Top fraction bit set on a quiet NaN

`define FPU_CANON_NAN 32'h7FC0_0000

// FCLASS bit positions in RISC-V order
`define FPU_CLS_NEG_INF   0
`define FPU_CLS_NEG_NORM  1
`define FPU_CLS_NEG_SUB   2
`define FPU_CLS_NEG_ZERO  3
`define FPU_CLS_POS_ZERO  4
`define FPU_CLS_POS_SUB   5
`define FPU_CLS_POS_NORM  6
`define FPU_CLS_POS_INF   7
`define FPU_CLS_SNAN      8
`define FPU_CLS_QNAN      9

`endif

// ==== common/fpu_lite_pkg.sv ====
// Opcode values above OP_MV_WX are legal on the port and decode to an all-zero result
`include "fpu_lite_defines.svh"

package fpu_lite_pkg;

  // ==========================================================================
  // Data words
  // ==========================================================================

  // Raw single-precision word
  typedef logic [`FPU_FLEN-1:0] fp_word_t;

  // Value bound for the integer register file
  typedef logic [`FPU_XLEN-1:0] int_word_t;

  // One-hot operand class
  // Bit order follows FCLASS so the mask is the FCLASS result directly
  typedef logic [`FPU_CLASS_W-1:0] fp_class_t;

  // ==========================================================================
  // Operation select
  // ==========================================================================

  // Compare kind is part of the opcode
  typedef enum logic [`FPU_OP_W-1:0] {
    OP_SGNJ   = 4'd0,    // Sign of b
    OP_SGNJN  = 4'd1,    // Inverted sign of b
    OP_SGNJX  = 4'd2,    // Sign of a XOR sign of b

    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,

    OP_FEQ    = 4'd5,    // Quiet compare
    OP_FLT    = 4'd6,    // Signaling compare
    OP_FLE    = 4'd7,    // Signaling compare

    OP_FCLASS = 4'd8,    // Class mask of a to int_result

    OP_MV_XW  = 4'd9,    // FP bits to integer port
    OP_MV_WX  = 4'd10    // Integer bits to FP port
  } fp_op_t;

  // Codes 11 to 15 are left unused

endpackage

// ==== operand_stage/fp_operand_stage.sv ====
// Payload registers load only on start and hold stale data that s1_valid qualifies
`include "fpu_lite_defines.svh"

module fp_operand_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  fpu_lite_pkg::fp_op_t    fp_alu_op,
  input  fpu_lite_pkg::fp_word_t  operand_a,
  input  fpu_lite_pkg::fp_word_t  operand_b,
  input  fpu_lite_pkg::int_word_t int_operand,
  output logic                    s1_valid,    // Operation in stage 2
  output fpu_lite_pkg::fp_op_t    s1_op,
  output fpu_lite_pkg::fp_word_t  s1_a,
  output fpu_lite_pkg::fp_word_t  s1_b,
  output fpu_lite_pkg::int_word_t s1_int,
  output fpu_lite_pkg::fp_class_t s1_class_a,  // One-hot
  output fpu_lite_pkg::fp_class_t s1_class_b   // One-hot
);
  import fpu_lite_pkg::*;

  fp_class_t class_a;   // Decoded before the register
  fp_class_t class_b;

  // ==========================================================================
  // Operand classification
  // ==========================================================================

  // Exactly one bit set for any input pattern
  function automatic fp_class_t classify(input fp_word_t w);
    logic                  sgn;
    logic [`FPU_EXP_W-1:0] expo;
    logic [`FPU_MAN_W-1:0] frac;
    fp_class_t             cls;

    sgn  = w[`FPU_SIGN_BIT];
    expo = w[`FPU_EXP_MSB:`FPU_EXP_LSB];
    frac = w[`FPU_MAN_W-1:0];
    cls  = '0;

    if (expo == '1) begin                     // Inf or NaN
      if (frac == '0) begin
        if (sgn) cls[`FPU_CLS_NEG_INF] = 1'b1;
        else     cls[`FPU_CLS_POS_INF] = 1'b1;
      end else if (frac[`FPU_QNAN_BIT]) begin
        cls[`FPU_CLS_QNAN] = 1'b1;            // Quiet NaN of either sign
      end else begin
        cls[`FPU_CLS_SNAN] = 1'b1;
      end
    end else if (expo == '0) begin            // Zero or subnormal
      if (frac == '0) begin
        if (sgn) cls[`FPU_CLS_NEG_ZERO] = 1'b1;
        else     cls[`FPU_CLS_POS_ZERO] = 1'b1;
      end else begin
        if (sgn) cls[`FPU_CLS_NEG_SUB] = 1'b1;
        else     cls[`FPU_CLS_POS_SUB] = 1'b1;
      end
    end else begin                            // Any other exponent
      if (sgn) cls[`FPU_CLS_NEG_NORM] = 1'b1;
      else     cls[`FPU_CLS_POS_NORM] = 1'b1;
    end

    return cls;
  endfunction

  assign class_a = classify(operand_a);
  assign class_b = classify(operand_b);

  // ==========================================================================
  // Stage 1 registers
  // ==========================================================================

  // Valid follows start one cycle later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= start;
    end
  end

  // Payload captured with the request
  always_ff @(posedge clk) begin
    if (start) begin
      s1_op      <= fp_alu_op;
      s1_a       <= operand_a;
      s1_b       <= operand_b;
      s1_int     <= int_operand;
      s1_class_a <= class_a;
      s1_class_b <= class_b;
    end
  end

endmodule

// ==== result_stage/fp_order_unit.sv ====
// Purely combinational and relies on the stage 1 class masks being one-hot
`include "fpu_lite_defines.svh"

module fp_order_unit (
  input  fpu_lite_pkg::fp_op_t    s1_op,
  input  fpu_lite_pkg::fp_word_t  s1_a,
  input  fpu_lite_pkg::fp_word_t  s1_b,
  input  fpu_lite_pkg::fp_class_t s1_class_a,
  input  fpu_lite_pkg::fp_class_t s1_class_b,
  output logic                    cmp_true,      // FEQ/FLT/FLE outcome
  output fpu_lite_pkg::fp_word_t  minmax_value,
  output logic                    order_nv
);
  import fpu_lite_pkg::*;

  logic                   sign_a;
  logic                   sign_b;
  logic [`FPU_FLEN-2:0]   mag_a;          // Exponent and fraction
  logic [`FPU_FLEN-2:0]   mag_b;
  logic                   a_nan;
  logic                   b_nan;
  logic                   any_nan;
  logic                   any_snan;
  logic                   both_zero;
  logic                   a_below_b;      // Total order with -0 below +0
  logic                   lt;
  logic                   eq;

  // ==========================================================================
  // Operand ordering
  // ==========================================================================
  assign sign_a = s1_a[`FPU_SIGN_BIT];
  assign sign_b = s1_b[`FPU_SIGN_BIT];
  assign mag_a  = s1_a[`FPU_SIGN_BIT-1:0];
  assign mag_b  = s1_b[`FPU_SIGN_BIT-1:0];

  assign a_nan    = s1_class_a[`FPU_CLS_SNAN] | s1_class_a[`FPU_CLS_QNAN];
  assign b_nan    = s1_class_b[`FPU_CLS_SNAN] | s1_class_b[`FPU_CLS_QNAN];
  assign any_nan  = a_nan | b_nan;
  assign any_snan = s1_class_a[`FPU_CLS_SNAN] | s1_class_b[`FPU_CLS_SNAN];

  assign both_zero = (s1_class_a[`FPU_CLS_NEG_ZERO] | s1_class_a[`FPU_CLS_POS_ZERO]) &
                     (s1_class_b[`FPU_CLS_NEG_ZERO] | s1_class_b[`FPU_CLS_POS_ZERO]);

  // Sign decides first and magnitude order flips for negatives
  assign a_below_b = (sign_a != sign_b) ? sign_a :
                     sign_a             ? (mag_a > mag_b) :
                                          (mag_a < mag_b);

  assign lt = a_below_b & ~both_zero;           // Zeros compare equal here
  assign eq = (s1_a == s1_b) | both_zero;

  // ==========================================================================
  // Compare and min/max outputs
  // ==========================================================================
  always_comb begin
    cmp_true = 1'b0;
    order_nv = 1'b0;
    case (s1_op)
      OP_FEQ: begin
        cmp_true = ~any_nan & eq;
        order_nv = any_snan;                    // Quiet compare
      end
      OP_FLT: begin
        cmp_true = ~any_nan & lt;
        order_nv = any_nan;                     // Signaling compare
      end
      OP_FLE: begin
        cmp_true = ~any_nan & (lt | eq);
        order_nv = any_nan;
      end
      OP_FMIN, OP_FMAX: order_nv = any_snan;
      default: ;                                // No flag for other ops
    endcase
  end

  // NaN operands lose to numbers
  always_comb begin
    if (a_nan & b_nan)        minmax_value = `FPU_CANON_NAN;
    else if (a_nan)           minmax_value = s1_b;
    else if (b_nan)           minmax_value = s1_a;
    else if (s1_op == OP_FMAX) minmax_value = a_below_b ? s1_b : s1_a;
    else                      minmax_value = a_below_b ? s1_a : s1_b;
  end

endmodule

// ==== result_stage/fp_result_stage.sv ====
// Outputs read zero on every cycle without done and only one result port carries data
`include "fpu_lite_defines.svh"

module fp_result_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    s1_valid,
  input  fpu_lite_pkg::fp_op_t    s1_op,
  input  fpu_lite_pkg::fp_word_t  s1_a,
  input  fpu_lite_pkg::fp_word_t  s1_b,
  input  fpu_lite_pkg::int_word_t s1_int,
  input  fpu_lite_pkg::fp_class_t s1_class_a,
  input  fpu_lite_pkg::fp_class_t s1_class_b,
  output logic                    done,         // One-cycle pulse
  output fpu_lite_pkg::fp_word_t  fp_result,
  output fpu_lite_pkg::int_word_t int_result,
  output logic                    flag_nv
);
  import fpu_lite_pkg::*;

  // Order unit results
  logic      cmp_true;
  fp_word_t  minmax_value;
  logic      order_nv;

  // Sign injection
  logic      inj_sign;
  fp_word_t  sgnj_value;

  // Next register values
  fp_word_t  fp_next;
  int_word_t int_next;
  logic      nv_next;

  // ==========================================================================
  // Ordering operations
  // ==========================================================================
  fp_order_unit u_order (
    .s1_op        (s1_op),
    .s1_a         (s1_a),
    .s1_b         (s1_b),
    .s1_class_a   (s1_class_a),
    .s1_class_b   (s1_class_b),
    .cmp_true     (cmp_true),
    .minmax_value (minmax_value),
    .order_nv     (order_nv)
  );

  // ==========================================================================
  // Sign injection
  // ==========================================================================

  // Shared by all three variants
  always_comb begin
    case (s1_op)
      OP_SGNJN: inj_sign = ~s1_b[`FPU_SIGN_BIT];
      OP_SGNJX: inj_sign = s1_a[`FPU_SIGN_BIT] ^ s1_b[`FPU_SIGN_BIT];
      default:  inj_sign = s1_b[`FPU_SIGN_BIT];  // Plain FSGNJ
    endcase
  end

  // Magnitude of a is never touched including any NaN payload
  assign sgnj_value = {inj_sign, s1_a[`FPU_SIGN_BIT-1:0]};

  // ==========================================================================
  // Result select
  // ==========================================================================
  always_comb begin
    fp_next  = '0;
    int_next = '0;
    nv_next  = 1'b0;
    case (s1_op)
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        fp_next = sgnj_value;                  // Never raises a flag
      end
      OP_FMIN, OP_FMAX: begin
        fp_next = minmax_value;
        nv_next = order_nv;
      end
      OP_FEQ, OP_FLT, OP_FLE: begin
        int_next = {{(`FPU_XLEN-1){1'b0}}, cmp_true};
        nv_next  = order_nv;
      end
      OP_FCLASS: begin
        // Mask already in FCLASS bit order
        int_next = {{(`FPU_XLEN-`FPU_CLASS_W){1'b0}}, s1_class_a};
      end
      OP_MV_XW: int_next = s1_a;               // Raw bit copy
      OP_MV_WX: fp_next  = s1_int;
      default: ;                               // Unused codes give zeros
    endcase
  end

  // ==========================================================================
  // Output register
  // ==========================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done       <= 1'b0;
      fp_result  <= '0;
      int_result <= '0;
      flag_nv    <= 1'b0;
    end else begin
      done <= s1_valid;
      if (s1_valid) begin
        fp_result  <= fp_next;
        int_result <= int_next;
        flag_nv    <= nv_next;
      end else begin
        fp_result  <= '0;                      // Idle cycles read zero
        int_result <= '0;
        flag_nv    <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/fpu_lite_top.sv ====
// Fixed two-cycle latency with no stall input so the caller must take every done pulse
module fpu_lite_top (
  input  logic                    clk,
  input  logic                    arst_n,

  // Request side
  input  logic                    start,        // One cycle per operation
  input  fpu_lite_pkg::fp_op_t    fp_alu_op,
  input  fpu_lite_pkg::fp_word_t  operand_a,    // rs1
  input  fpu_lite_pkg::fp_word_t  operand_b,    // rs2
  input  fpu_lite_pkg::int_word_t int_operand,  // Source of FMV.W.X

  // Response side
  output logic                    done,         // Two edges after start
  output fpu_lite_pkg::fp_word_t  fp_result,
  output fpu_lite_pkg::int_word_t int_result,
  output logic                    flag_nv       // Invalid operation
);
  import fpu_lite_pkg::*;

  // ==========================================================================
  // Stage 1 to stage 2 wires
  // ==========================================================================
  logic      s1_valid;
  fp_op_t    s1_op;
  fp_word_t  s1_a;
  fp_word_t  s1_b;
  int_word_t s1_int;
  fp_class_t s1_class_a;
  fp_class_t s1_class_b;

  // Classify and capture operands
  fp_operand_stage u_operand_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .fp_alu_op   (fp_alu_op),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .s1_valid    (s1_valid),
    .s1_op       (s1_op),
    .s1_a        (s1_a),
    .s1_b        (s1_b),
    .s1_int      (s1_int),
    .s1_class_a  (s1_class_a),
    .s1_class_b  (s1_class_b)
  );

  // Compute, select and register the result
  fp_result_stage u_result_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_a       (s1_a),
    .s1_b       (s1_b),
    .s1_int     (s1_int),
    .s1_class_a (s1_class_a),
    .s1_class_b (s1_class_b),
    .done       (done),
    .fp_result  (fp_result),
    .int_result (int_result),
    .flag_nv    (flag_nv)
  );

endmodule

// ==== tests/tb_fpu_lite.sv ====
// Results are checked at the falling edge and every expected value carries its due cycle
module tb_fpu_lite;
  import fpu_lite_pkg::*;

  localparam int       total_ops = 300;            // 120 + 50 + 10 + 20 + 100
  localparam fp_word_t canon_nan = 32'h7FC0_0000;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      start;
  fp_op_t    fp_alu_op;
  fp_word_t  operand_a;
  fp_word_t  operand_b;
  int_word_t int_operand;
  logic      done;
  fp_word_t  fp_result;
  int_word_t int_result;
  logic      flag_nv;

  // Pending results, oldest first
  fp_word_t  exp_fp_q[$];
  int_word_t exp_int_q[$];
  logic      exp_nv_q[$];
  int        due_q[$];                             // Falling edge where done is due

  int        neg_count;
  int        error_count;
  int        check_count;

  // One operand of each FCLASS class, in mask bit order
  fp_word_t  specials [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000,
                               32'h0000_0000, 32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000,
                               32'h7F80_0001, 32'h7FC0_0000};

  fpu_lite_top uut (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .fp_alu_op   (fp_alu_op),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .done        (done),
    .fp_result   (fp_result),
    .int_result  (int_result),
    .flag_nv     (flag_nv)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // FCLASS bit index of a word
  function automatic int class_index(input fp_word_t w);
    if (w[30:23] == 8'hFF) begin
      if (w[22:0] == '0) return w[31] ? 0 : 7;
      return w[22] ? 9 : 8;                         // Top fraction bit marks quiet
    end
    if (w[30:23] == 8'h00) begin
      if (w[22:0] == '0) return w[31] ? 3 : 4;
      return w[31] ? 2 : 5;
    end
    return w[31] ? 1 : 6;
  endfunction

  // Signed position on the real line with both zeros at 0
  function automatic longint order_key(input fp_word_t w);
    longint m;
    m = w[30:0];
    return w[31] ? -m : m;
  endfunction

  function automatic void model(input fp_op_t op, input fp_word_t a, input fp_word_t b,
                                input int_word_t iv, output fp_word_t fp,
                                output int_word_t ir, output logic nv);
    int     ca;
    int     cb;
    logic   a_nan;
    logic   b_nan;
    logic   snan;
    logic   a_low;
    longint ka;
    longint kb;
    ca    = class_index(a);
    cb    = class_index(b);
    a_nan = (ca >= 8);
    b_nan = (cb >= 8);
    snan  = (ca == 8) || (cb == 8);
    ka    = order_key(a);
    kb    = order_key(b);
    a_low = (ka < kb) || (ka == kb && a[31] && !b[31]);   // -0 below +0
    fp    = '0;
    ir    = '0;
    nv    = 1'b0;
    case (op)
      OP_SGNJ:  fp = {b[31], a[30:0]};
      OP_SGNJN: fp = {~b[31], a[30:0]};
      OP_SGNJX: fp = {a[31] ^ b[31], a[30:0]};
      OP_FMIN, OP_FMAX: begin
        nv = snan;
        if (a_nan && b_nan) fp = canon_nan;
        else if (a_nan)     fp = b;
        else if (b_nan)     fp = a;
        else                fp = ((op == OP_FMIN) == a_low) ? a : b;
      end
      OP_FEQ: begin
        nv = snan;                                  // Quiet compare
        ir = (!a_nan && !b_nan && ka == kb) ? 32'd1 : 32'd0;
      end
      OP_FLT: begin
        nv = a_nan || b_nan;
        ir = (!a_nan && !b_nan && ka < kb) ? 32'd1 : 32'd0;
      end
      OP_FLE: begin
        nv = a_nan || b_nan;
        ir = (!a_nan && !b_nan && ka <= kb) ? 32'd1 : 32'd0;
      end
      OP_FCLASS: ir = 32'd1 << ca;
      OP_MV_XW:  ir = a;
      OP_MV_WX:  fp = iv;
      default: ;                                    // Unused codes give zeros
    endcase
  endfunction

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  task automatic issue_expect(input fp_op_t op, input fp_word_t a, input fp_word_t b,
                              input int_word_t iv, input fp_word_t efp,
                              input int_word_t eint, input logic env);
    @(posedge clk);
    start       <= 1'b1;
    fp_alu_op   <= op;
    operand_a   <= a;
    operand_b   <= b;
    int_operand <= iv;
    exp_fp_q.push_back(efp);
    exp_int_q.push_back(eint);
    exp_nv_q.push_back(env);
    due_q.push_back(neg_count + 3);                 // Two edges after the sampling edge
  endtask

  task automatic issue(input fp_op_t op, input fp_word_t a, input fp_word_t b,
                       input int_word_t iv);
    fp_word_t  efp;
    int_word_t eint;
    logic      env;
    model(op, a, b, iv, efp, eint, env);
    issue_expect(op, a, b, iv, efp, eint, env);
  endtask

  // Stop issuing and let the pipeline empty
  task automatic drain();
    int n;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (due_q.size() > 0 && n < 10) begin
      @(negedge clk);
      n++;
    end
  endtask

  // Mostly random bits with an occasional special value
  function automatic fp_word_t rand_operand();
    if ($urandom_range(0, 3) == 0) return specials[$urandom_range(0, 9)];
    return $urandom;
  endfunction

  // ==========================================================================
  // Result monitor
  // ==========================================================================
  always @(negedge clk) begin : monitor
    fp_word_t  efp;
    int_word_t eint;
    logic      env;
    neg_count++;
    while (due_q.size() > 0 && due_q[0] < neg_count) begin
      $display("missing done for an operation due at falling edge %0d", due_q[0]);
      error_count++;
      void'(due_q.pop_front());
      void'(exp_fp_q.pop_front());
      void'(exp_int_q.pop_front());
      void'(exp_nv_q.pop_front());
    end
    check_count++;
    if (done && (due_q.size() == 0 || due_q[0] != neg_count)) begin
      $display("done rose at time %0t with no operation due", $time);
      error_count++;
    end else if (done) begin
      void'(due_q.pop_front());
      efp  = exp_fp_q.pop_front();
      eint = exp_int_q.pop_front();
      env  = exp_nv_q.pop_front();
      if (fp_result !== efp) begin
        $display("error at %0t: fp_result expected %h got %h", $time, efp, fp_result);
        error_count++;
      end
      if (int_result !== eint) begin
        $display("error at %0t: int_result expected %h got %h", $time, eint, int_result);
        error_count++;
      end
      if (flag_nv !== env) begin
        $display("error at %0t: flag_nv expected %b got %b", $time, env, flag_nv);
        error_count++;
      end
    end else if ({fp_result, int_result, flag_nv} !== '0) begin   // Idle outputs read zero
      $display("outputs not zero at time %0t while done is low", $time);
      error_count++;
    end
  end

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic reset_outputs();
    repeat (3) begin
      @(negedge clk);
      check_count++;
      if (done !== 1'b0 || flag_nv !== 1'b0 || fp_result !== '0 || int_result !== '0) begin
        $display("outputs not cleared after reset at time %0t", $time);
        error_count++;
      end
    end
  endtask

  task automatic sign_injection();
    fp_word_t a;
    fp_word_t b;
    repeat (40) begin
      a = $urandom;
      b = $urandom;
      issue(OP_SGNJ, a, b, $urandom);
      issue(OP_SGNJN, a, b, $urandom);
      issue(OP_SGNJX, a, b, $urandom);
    end
    drain();
  endtask

  task automatic compare_minmax();
    // Zeros, equal, ordered negatives, NaNs on each side
    fp_word_t cmp_a [10] = '{32'h0000_0000, 32'h8000_0000, 32'h3FC0_0000, 32'hC000_0000,
                             32'hBF80_0000, 32'h7FC0_0000, 32'h3F80_0000, 32'h7F80_0001,
                             32'h3F80_0000, 32'h7FC0_0000};
    fp_word_t cmp_b [10] = '{32'h8000_0000, 32'h0000_0000, 32'h3FC0_0000, 32'hBF80_0000,
                             32'hC000_0000, 32'h3F80_0000, 32'h7FC0_0000, 32'h3F80_0000,
                             32'h7F80_0001, 32'hFFA0_0000};
    fp_op_t   ops [5]    = '{OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX};
    for (int i = 0; i < 10; i++) begin
      for (int k = 0; k < 5; k++) issue(ops[k], cmp_a[i], cmp_b[i], 32'h0);
    end
    drain();
  endtask

  // Expected mask is the table position
  task automatic fclass_per_class();
    for (int i = 0; i < 10; i++) begin
      issue_expect(OP_FCLASS, specials[i], $urandom, $urandom, '0, 32'd1 << i, 1'b0);
    end
    drain();
  endtask

  task automatic move_bits();
    int_word_t bits;
    repeat (10) begin
      bits = $urandom;
      issue_expect(OP_MV_XW, bits, $urandom, $urandom, '0, bits, 1'b0);
      bits = $urandom;
      issue_expect(OP_MV_WX, $urandom, $urandom, bits, bits, '0, 1'b0);
    end
    drain();
  endtask

  // Back-to-back issue including unused codes
  task automatic random_stream();
    repeat (100) begin
      issue(fp_op_t'(4'($urandom_range(0, 15))), rand_operand(), rand_operand(), $urandom);
    end
    drain();
  endtask

  // ==========================================================================
  // Run control
  // ==========================================================================
  initial begin
    #((total_ops * 4 + 100) * 20);
    $display("watchdog expired with %0d results still pending", due_q.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(38));
    neg_count   = 0;
    error_count = 0;
    check_count = 0;
    arst_n      = 1'b0;
    start       = 1'b0;
    fp_alu_op   = OP_SGNJ;
    operand_a   = '0;
    operand_b   = '0;
    int_operand = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    reset_outputs();
    sign_injection();
    compare_minmax();
    fclass_per_class();
    move_bits();
    random_stream();
    repeat (4) @(negedge clk);                      // Let late done pulses show up
    if (due_q.size() > 0) begin
      $display("%0d operations never produced done", due_q.size());
      error_count++;
    end
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+common
common/fpu_lite_pkg.sv
operand_stage/fp_operand_stage.sv
result_stage/fp_order_unit.sv
result_stage/fp_result_stage.sv
rtl/fpu_lite_top.sv
tests/tb_fpu_lite.sv
